/* verilog/axis_lbus_pkg.sv */
package axis_lbus_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int beat_bytes    = 8;   // stream beat width in bytes
    localparam int seg_bytes     = 16;  // one LBUS segment
    localparam int seg_cnt       = 4;   // segments per row, power of two
    localparam int lane_ptr_bits = 2;
    localparam int mty_bits      = 4;
    localparam int fifo_depth    = 16;  // words per lane

    // must be able to count a lane full of one-row packets
    localparam int pkt_cnt_bits  = 5;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // stream input beat
    typedef struct packed {
        logic [beat_bytes*8-1:0] data;
        logic [beat_bytes-1:0]   keep;  // bit 0 = first byte, contiguous
        logic                    last;
    } axis_beat_t;

    // one segment as stored in a lane FIFO
    // first stream byte sits in data[127:120]
    typedef struct packed {
        logic [seg_bytes*8-1:0] data;
        logic [mty_bits-1:0]    mty;   // empty bytes at the low end
        logic                   eop;
        logic                   sop;
        logic                   ena;   // low on idle fill words
    } seg_word_t;

    // one LBUS transmit lane
    typedef struct packed {
        logic [seg_bytes*8-1:0] data;
        logic                   ena;
        logic                   sop;
        logic                   eop;
        logic [mty_bits-1:0]    mty;
    } lbus_seg_t;

endpackage

/* verilog/beat_packer.sv */
module beat_packer import axis_lbus_pkg::*; (
    input  logic       tx_clk,
    input  logic       tx_resetn,

    input  axis_beat_t s_beat,
    input  logic       s_tvalid,
    output logic       s_tready,

    output seg_word_t  pk_word,
    output logic       pk_valid,
    input  logic       pk_take
);

    logic                    half;        // upper half already holds a beat
    logic                    accept;
    logic                    complete;    // this beat closes the word
    logic [beat_bytes*8-1:0] beat_rev;
    logic [mty_bits:0]       valid_bytes; // 0..16, needs one extra bit

    // stream byte 0 goes to the top byte
    function automatic logic [beat_bytes*8-1:0] reverse_bytes(
        input logic [beat_bytes*8-1:0] d
    );
        logic [beat_bytes*8-1:0] r;
        for (int i = 0; i < beat_bytes; i++) begin
            r[(beat_bytes-1-i)*8 +: 8] = d[i*8 +: 8];
        end
        return r;
    endfunction

    function automatic logic [mty_bits:0] keep_bytes(
        input logic [beat_bytes-1:0] k
    );
        logic [mty_bits:0] n;
        n = '0;
        for (int i = 0; i < beat_bytes; i++) begin
            n = n + (mty_bits+1)'(k[i]);
        end
        return n;
    endfunction

    assign accept   = s_tvalid & s_tready;
    assign complete = half | s_beat.last;
    assign s_tready = ~pk_valid | pk_take;   // free, or emptied this cycle
    assign beat_rev = reverse_bytes(s_beat.data);

    // first half is always full when the second one arrives
    assign valid_bytes = keep_bytes(s_beat.keep)
                       + (half ? (mty_bits+1)'(beat_bytes) : '0);

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge tx_clk) begin
        if (!tx_resetn) begin
            half     <= 1'b0;
            pk_valid <= 1'b0;
        end else begin
            if (pk_take) begin
                pk_valid <= 1'b0;
            end
            if (accept) begin
                half <= ~complete;
                if (complete) begin
                    pk_valid <= 1'b1;   // wins over the take above
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // word assembly
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge tx_clk) begin
        if (accept) begin
            pk_word.sop <= 1'b0;   // controller decides sop
            pk_word.ena <= 1'b1;
            pk_word.eop <= s_beat.last;
            pk_word.mty <= mty_bits'(seg_bytes - valid_bytes);
            if (half) begin
                pk_word.data[beat_bytes*8-1:0] <= beat_rev;
            end else begin
                // lower half cleared in case this beat is also the last
                pk_word.data <= {beat_rev, {beat_bytes*8{1'b0}}};
            end
        end
    end

endmodule

/* verilog/segment_fifo.sv */
module segment_fifo import axis_lbus_pkg::*; #(
    parameter int depth = fifo_depth
) (
    input  logic      tx_clk,
    input  logic      tx_resetn,

    input  logic      wr_en,
    input  seg_word_t wr_word,
    input  logic      rd_en,
    output seg_word_t head,
    output logic      full
);

    seg_word_t                mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth):0]   count;
    logic                     do_wr;
    logic                     do_rd;

    function automatic logic [$clog2(depth)-1:0] bump(
        input logic [$clog2(depth)-1:0] p
    );
        return (p == depth-1) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == ($clog2(depth)+1)'(depth));
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & (count != '0);   // reads of an empty lane dropped
    assign head  = mem[rd_ptr];             // fall-through head

    always_ff @(posedge tx_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge tx_clk) begin
        if (!tx_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/lbus_row_control.sv */
module lbus_row_control import axis_lbus_pkg::*; (
    input  logic               tx_clk,
    input  logic               tx_resetn,

    // from the packer
    input  seg_word_t          pk_word,
    input  logic               pk_valid,
    output logic               pk_take,

    // lane FIFO write side
    output logic [seg_cnt-1:0] wr_en,
    output seg_word_t          wr_word,

    // lane FIFO read side
    output logic               rd_en,
    input  logic [seg_cnt-1:0] lane_full,
    input  seg_word_t          lane_head [seg_cnt],

    // LBUS
    input  logic               tx_rdyout,
    output lbus_seg_t          tx_seg [seg_cnt]
);

    logic [lane_ptr_bits-1:0] lane_ptr;
    logic                     fill;       // idle words pending to end the row
    logic                     in_pkt;     // low means next segment is sop
    logic [pkt_cnt_bits-1:0]  pkt_cnt;    // complete packets stored

    logic last_lane;
    logic idle_wr;
    logic lane_wr;
    logic pkt_done;
    logic pkt_avail;
    logic row_eop;

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    assign last_lane = &lane_ptr;   // seg_cnt is a power of two
    assign pk_take   = pk_valid & ~lane_full[lane_ptr] & ~fill;
    assign idle_wr   = fill & ~lane_full[lane_ptr];
    assign lane_wr   = pk_take | idle_wr;

    // row closed on a packet end, either by data or by the last idle
    assign pkt_done = last_lane & (idle_wr | (pk_take & pk_word.eop));

    always_comb begin
        wr_en           = '0;
        wr_en[lane_ptr] = lane_wr;
    end

    always_comb begin
        if (fill) begin
            wr_word = '0;   // idle segment
        end else begin
            wr_word     = pk_word;
            wr_word.sop = ~in_pkt;
            wr_word.ena = 1'b1;
        end
    end

    always_ff @(posedge tx_clk) begin
        if (!tx_resetn) begin
            lane_ptr <= '0;
            fill     <= 1'b0;
            in_pkt   <= 1'b0;
        end else begin
            if (lane_wr) begin
                lane_ptr <= lane_ptr + 1'b1;   // wraps after lane 3
            end
            if (pk_take) begin
                in_pkt <= ~pk_word.eop;
                if (pk_word.eop && !last_lane) begin
                    fill <= 1'b1;
                end
            end else if (idle_wr && last_lane) begin
                fill <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    assign pkt_avail = |pkt_cnt;
    assign rd_en     = tx_rdyout & pkt_avail;   // whole row at once

    always_comb begin
        row_eop = 1'b0;
        for (int i = 0; i < seg_cnt; i++) begin
            row_eop = row_eop | lane_head[i].eop;
        end
    end

    always_ff @(posedge tx_clk) begin
        if (!tx_resetn) begin
            pkt_cnt <= '0;
        end else begin
            case ({pkt_done, rd_en & row_eop})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;   // both or neither
            endcase
        end
    end

    // nothing leaves until a full packet is stored
    always_comb begin
        for (int i = 0; i < seg_cnt; i++) begin
            tx_seg[i].data = lane_head[i].data;
            tx_seg[i].mty  = lane_head[i].mty;
            tx_seg[i].ena  = lane_head[i].ena & pkt_avail;
            tx_seg[i].sop  = lane_head[i].sop & pkt_avail;
            tx_seg[i].eop  = lane_head[i].eop & pkt_avail;
        end
    end

endmodule

/* verilog/axis_to_lbus.sv */
module axis_to_lbus import axis_lbus_pkg::*; (
    input  logic       tx_clk,
    input  logic       tx_resetn,

    // stream input
    input  axis_beat_t s_beat,
    input  logic       s_tvalid,
    output logic       s_tready,

    // LBUS transmit
    input  logic       tx_rdyout,
    output lbus_seg_t  tx_seg [seg_cnt]
);

    // packer to controller
    seg_word_t          pk_word;
    logic               pk_valid;
    logic               pk_take;

    // controller to lanes
    logic [seg_cnt-1:0] wr_en;
    seg_word_t          wr_word;
    logic               rd_en;
    logic [seg_cnt-1:0] lane_full;
    seg_word_t          lane_head [seg_cnt];

    //////////////////////////////////////////////////////////////////////
    // two beats into one segment
    //////////////////////////////////////////////////////////////////////

    beat_packer u_packer (
        .tx_clk    (tx_clk),
        .tx_resetn (tx_resetn),
        .s_beat    (s_beat),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .pk_word   (pk_word),
        .pk_valid  (pk_valid),
        .pk_take   (pk_take)
    );

    //////////////////////////////////////////////////////////////////////
    // lane distribution and packet release
    //////////////////////////////////////////////////////////////////////

    lbus_row_control u_ctrl (
        .tx_clk    (tx_clk),
        .tx_resetn (tx_resetn),
        .pk_word   (pk_word),
        .pk_valid  (pk_valid),
        .pk_take   (pk_take),
        .wr_en     (wr_en),
        .wr_word   (wr_word),
        .rd_en     (rd_en),
        .lane_full (lane_full),
        .lane_head (lane_head),
        .tx_rdyout (tx_rdyout),
        .tx_seg    (tx_seg)
    );

    //////////////////////////////////////////////////////////////////////
    // one FIFO per LBUS lane
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < seg_cnt; i++) begin : g_lane
        segment_fifo #(
            .depth (fifo_depth)
        ) u_fifo (
            .tx_clk    (tx_clk),
            .tx_resetn (tx_resetn),
            .wr_en     (wr_en[i]),
            .wr_word   (wr_word),      // shared, only one lane enabled
            .rd_en     (rd_en),        // all lanes pop together
            .head      (lane_head[i]),
            .full      (lane_full[i])
        );
    end

endmodule

/* bench/axis_to_lbus_tb.sv */
module axis_to_lbus_tb import axis_lbus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // one row of the packet table
    typedef struct packed {
        logic [7:0] len;        // payload bytes, 1..200
        logic       gaps;       // random tvalid gaps
        logic       stall;      // random tx_rdyout low cycles
        logic       hold_rdy;   // rdyout low until the stream backs up
        logic       hold_last;  // last beat withheld for a while
    } pkt_entry_t;

    localparam pkt_entry_t fixed_tbl [14] = '{
        '{8'd64,  1'b0, 1'b0, 1'b0, 1'b0},   // exactly one row
        '{8'd20,  1'b0, 1'b0, 1'b0, 1'b0},   // two segments plus idles
        '{8'd100, 1'b0, 1'b0, 1'b0, 1'b1},
        '{8'd200, 1'b0, 1'b0, 1'b1, 1'b0},   // start of the back-pressure group
        '{8'd200, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'd200, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'd200, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'd200, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'd200, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'd1,   1'b1, 1'b1, 1'b0, 1'b0},
        '{8'd8,   1'b1, 1'b1, 1'b0, 1'b0},
        '{8'd9,   1'b1, 1'b0, 1'b0, 1'b0},
        '{8'd16,  1'b0, 1'b1, 1'b0, 1'b0},
        '{8'd17,  1'b1, 1'b1, 1'b0, 1'b0}
    };

    logic       tx_clk = 1'b0;
    logic       tx_resetn;
    axis_beat_t s_beat;
    logic       s_tvalid;
    logic       s_tready;
    logic       tx_rdyout;
    lbus_seg_t  tx_seg [seg_cnt];

    pkt_entry_t table_q [$];
    lbus_seg_t  exp_q [$];       // expected lanes, whole rows in order
    logic [7:0] payload [$];

    logic quiet;                 // no lane may show ena
    logic stall_en;
    logic hold_rdy;
    logic tready_dropped;
    int   low_cycles;
    int   held_cycles;
    int   cycle_cnt = 0;
    int   timeout_limit = 200;

    axis_to_lbus UUT (
        .tx_clk    (tx_clk),
        .tx_resetn (tx_resetn),
        .s_beat    (s_beat),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .tx_rdyout (tx_rdyout),
        .tx_seg    (tx_seg)
    );

    always #20 tx_clk = ~tx_clk;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task fail_now;
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task check_flag(input logic exp, input logic act, input string name);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task check_seg(input lbus_seg_t exp, input lbus_seg_t act, input int lane);
        if (act.data !== exp.data) begin
            $display("mismatch tx_seg[%0d].data expected %h actual %h", lane, exp.data, act.data);
            fail_now();
        end
        if (act.mty !== exp.mty) begin
            $display("mismatch tx_seg[%0d].mty expected %h actual %h", lane, exp.mty, act.mty);
            fail_now();
        end
        if (act.sop !== exp.sop) begin
            $display("mismatch tx_seg[%0d].sop expected %h actual %h", lane, exp.sop, act.sop);
            fail_now();
        end
        if (act.eop !== exp.eop) begin
            $display("mismatch tx_seg[%0d].eop expected %h actual %h", lane, exp.eop, act.eop);
            fail_now();
        end
        if (act.ena !== exp.ena) begin
            $display("mismatch tx_seg[%0d].ena expected %h actual %h", lane, exp.ena, act.ena);
            fail_now();
        end
    endtask

    function logic row_has_ena();
        logic any;
        any = 1'b0;
        for (int i = 0; i < seg_cnt; i++) begin
            any = any | (tx_seg[i].ena === 1'b1);
        end
        return any;
    endfunction

    // a row is taken on every edge with ena shown and tx_rdyout high
    always @(posedge tx_clk) begin
        if (tx_resetn) begin
            if (quiet) begin
                for (int i = 0; i < seg_cnt; i++) begin
                    check_flag(1'b0, tx_seg[i].ena, $sformatf("tx_seg[%0d].ena", i));
                end
            end
            if (tx_rdyout && row_has_ena()) begin
                for (int i = 0; i < seg_cnt; i++) begin
                    if (exp_q.size() == 0) begin
                        $display("LBUS row shown with no packet outstanding");
                        fail_now();
                    end else begin
                        check_seg(exp_q.pop_front(), tx_seg[i], i);
                    end
                end
            end
        end
    end

    always @(posedge tx_clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("timeout after %0d cycles, the DUT stopped moving data", cycle_cnt);
            fail_now();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    always @(negedge tx_clk) begin
        if (hold_rdy) begin
            tx_rdyout = 1'b0;
            held_cycles = held_cycles + 1;
            low_cycles = s_tready ? 0 : low_cycles + 1;
            if (low_cycles >= 20) begin   // stream stalled long enough
                tready_dropped = 1'b1;
                hold_rdy = 1'b0;
            end else if (held_cycles >= 300) begin
                hold_rdy = 1'b0;          // no back-pressure seen, let rows drain
            end
        end else if (stall_en) begin
            tx_rdyout = ($urandom_range(2) != 0);
        end else begin
            tx_rdyout = 1'b1;
        end
    end

    // segments of 16 bytes, first byte on top, idles to end the row
    task build_expected;
        lbus_seg_t seg;
        int        nseg;
        int        idx;
        nseg = (payload.size() + seg_bytes - 1) / seg_bytes;
        for (int s = 0; s < nseg; s++) begin
            seg = '0;
            seg.ena = 1'b1;
            seg.sop = (s == 0);
            seg.eop = (s == nseg - 1);
            for (int j = 0; j < seg_bytes; j++) begin
                idx = s * seg_bytes + j;
                if (idx < payload.size()) begin
                    seg.data[(seg_bytes-1-j)*8 +: 8] = payload[idx];
                end else begin
                    seg.mty = seg.mty + 1'b1;
                end
            end
            exp_q.push_back(seg);
        end
        for (int s = nseg; s % seg_cnt != 0; s++) begin
            exp_q.push_back('0);
        end
    endtask

    task wait_drained;
        while (exp_q.size() != 0) begin
            @(negedge tx_clk);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task send_beat(input axis_beat_t beat);
        logic done;
        s_beat = beat;
        s_tvalid = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(posedge tx_clk);
            done = s_tready;
            @(negedge tx_clk);
        end
        s_tvalid = 1'b0;
    endtask

    task send_packet(input pkt_entry_t e);
        axis_beat_t beat;
        int         nbeats;
        int         idx;
        stall_en = e.stall;
        if (e.hold_rdy) begin
            hold_rdy = 1'b1;
        end
        if (e.hold_last) begin
            wait_drained();
            quiet = 1'b1;
        end
        payload.delete();
        for (int i = 0; i < e.len; i++) begin
            payload.push_back(8'($urandom));
        end
        build_expected();
        nbeats = (payload.size() + beat_bytes - 1) / beat_bytes;
        for (int i = 0; i < nbeats; i++) begin
            beat = '0;
            for (int j = 0; j < beat_bytes; j++) begin
                idx = i * beat_bytes + j;
                if (idx < payload.size()) begin
                    beat.data[j*8 +: 8] = payload[idx];
                    beat.keep[j] = 1'b1;
                end
            end
            beat.last = (i == nbeats - 1);
            if (e.hold_last && beat.last) begin
                repeat (24) @(negedge tx_clk);   // earlier segments sit stored
                quiet = 1'b0;
            end
            if (e.gaps && $urandom_range(3) == 0) begin
                repeat ($urandom_range(3, 1)) @(negedge tx_clk);
            end
            send_beat(beat);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        pkt_entry_t e;
        void'($urandom(32'hf64f2c00));
        tx_resetn = 1'b0;
        s_beat = '0;
        s_tvalid = 1'b0;
        tx_rdyout = 1'b1;
        quiet = 1'b0;
        stall_en = 1'b0;
        hold_rdy = 1'b0;
        tready_dropped = 1'b0;
        low_cycles = 0;
        held_cycles = 0;

        foreach (fixed_tbl[n]) begin
            table_q.push_back(fixed_tbl[n]);
        end
        for (int n = 0; n < 24; n++) begin
            e = '0;
            e.len = 8'($urandom_range(200, 1));
            e.gaps = 1'($urandom_range(1));
            e.stall = 1'($urandom_range(1));
            table_q.push_back(e);
        end
        timeout_limit = 40 * table_q.size() + 200;

        repeat (10) @(posedge tx_clk);
        @(negedge tx_clk);
        tx_resetn = 1'b1;

        @(posedge tx_clk);
        check_flag(1'b1, s_tready, "s_tready");
        for (int i = 0; i < seg_cnt; i++) begin
            check_flag(1'b0, tx_seg[i].ena, $sformatf("tx_seg[%0d].ena", i));
            check_flag(1'b0, tx_seg[i].sop, $sformatf("tx_seg[%0d].sop", i));
            check_flag(1'b0, tx_seg[i].eop, $sformatf("tx_seg[%0d].eop", i));
        end
        @(negedge tx_clk);

        foreach (table_q[n]) begin
            send_packet(table_q[n]);
        end
        wait_drained();
        repeat (20) @(negedge tx_clk);   // any stray row shows up here

        if (!tready_dropped) begin
            $display("s_tready never dropped while tx_rdyout was held low");
            fail_now();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* list.f */
verilog/axis_lbus_pkg.sv
verilog/beat_packer.sv
verilog/segment_fifo.sv
verilog/lbus_row_control.sv
verilog/axis_to_lbus.sv
bench/axis_to_lbus_tb.sv
